//--- Makefile
# Verilator build and run for the dual TCM subsystem

TOP := tcm_subsystem_tb
SIM := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): dual_tcm.f $(wildcard logic/*.sv) $(wildcard test/*.sv)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f dual_tcm.f

# Pass only if the log holds the pass line
run: $(SIM)
	./$(SIM) > sim.log 2>&1 ; cat sim.log
	grep -q '^Done: no errors$$' sim.log

clean:
	rm -rf obj_dir sim.log

//--- dual_tcm.f
logic/tcm_pkg.sv
logic/tcm_request_router.sv
logic/tcm_bank.sv
logic/tcm_response_router.sv
logic/tcm_subsystem.sv
test/tcm_subsystem_tb.sv

//--- logic/tcm_bank.sv
//================================================
// Single-cycle TCM bank, word RAM with byte-lane
// writes and a registered read port
//================================================
`timescale 1ns/1ps

module tcm_bank (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            bank_en,
   input  logic [tcm_pkg::ADDR_W-1:0]      bank_addr,
   input  logic [tcm_pkg::DATA_W-1:0]      bank_din,
   input  logic [tcm_pkg::BYTESEL_W-1:0]   bank_bytesel,
   output logic [tcm_pkg::DATA_W-1:0]      bank_dout,
   output logic                            bank_ready_nxt
);

   import tcm_pkg::*;

   // Storage array
   logic [DATA_W-1:0]  mem [BANK_DEPTH];
   // Word index from byte address
   logic [WORD_AW-1:0] word_idx;

   assign word_idx = bank_addr[ADDR_W-1:WORD_LSB];

   // Byte-lane write on accepted cycle
   always_ff @(posedge clk) begin
      if (bank_en) begin
         for (int i = 0; i < BYTESEL_W; i++) begin
            if (bank_bytesel[i]) begin
               mem[word_idx][i*LANE_W +: LANE_W] <= bank_din[i*LANE_W +: LANE_W];
            end
         end
      end
   end

   // Registered read, old word on a write
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         bank_dout <= '0;
      end else if (bank_en) begin
         bank_dout <= mem[word_idx];
      end
   end

   // No wait states
   assign bank_ready_nxt = bank_en;

endmodule

//--- logic/tcm_pkg.sv
//================================================
// TCM subsystem shared widths, bank indices and
// address region codes
//================================================
package tcm_pkg;

   // Core word and lane sizes
   localparam int DATA_W    = 32;
   localparam int BYTESEL_W = 4;
   localparam int LANE_W    = DATA_W / BYTESEL_W;

   // Byte address bits decoded inside one bank
   localparam int ADDR_W     = 12;
   // Word index drops the byte offset
   localparam int WORD_LSB   = $clog2(BYTESEL_W);
   localparam int WORD_AW    = ADDR_W - WORD_LSB;
   localparam int BANK_DEPTH = 1 << WORD_AW;

   // Bank count and select width
   localparam int NUM_BANKS  = 2;
   localparam int BANK_SEL_W = $clog2(NUM_BANKS);

   // Bank indices
   localparam logic [BANK_SEL_W-1:0] BANK_CODE = 1'b0;
   localparam logic [BANK_SEL_W-1:0] BANK_DATA = 1'b1;

   // Region field at the top of the address
   localparam int REGION_W   = 4;
   localparam int REGION_LSB = DATA_W - REGION_W;

   // Region codes
   localparam logic [REGION_W-1:0] REGION_CODE = 4'h0;
   localparam logic [REGION_W-1:0] REGION_DATA = 4'h2;

endpackage

//--- logic/tcm_request_router.sv
//================================================
// TCM request router: region decode, data-first
// arbitration and steering of requests to banks
//================================================
`timescale 1ns/1ps

module tcm_request_router (
   // Code port, read only
   input  logic [tcm_pkg::DATA_W-1:0]                             code_addr,
   input  logic                                                   code_req,
   // Data port
   input  logic [tcm_pkg::DATA_W-1:0]                             data_addr,
   input  logic [tcm_pkg::DATA_W-1:0]                             data_wdata,
   input  logic [tcm_pkg::BYTESEL_W-1:0]                          data_bytesel,
   input  logic                                                   data_req,
   // Bank side
   input  logic [tcm_pkg::NUM_BANKS-1:0]                          bank_ready_nxt,
   output logic [tcm_pkg::NUM_BANKS-1:0]                          bank_en,
   output logic [tcm_pkg::NUM_BANKS-1:0][tcm_pkg::ADDR_W-1:0]     bank_addr,
   output logic [tcm_pkg::NUM_BANKS-1:0][tcm_pkg::DATA_W-1:0]     bank_din,
   output logic [tcm_pkg::NUM_BANKS-1:0][tcm_pkg::BYTESEL_W-1:0]  bank_bytesel,
   // To response router and core
   output logic                                                   code_early_ready,
   output logic                                                   data_early_ready,
   output logic [tcm_pkg::BANK_SEL_W-1:0]                         code_bank_sel,
   output logic [tcm_pkg::BANK_SEL_W-1:0]                         data_bank_sel
);

   import tcm_pkg::*;

   // Decoded requests per port
   logic                  code_ok;
   logic                  data_ok;
   logic [BANK_SEL_W-1:0] code_bank;
   logic [BANK_SEL_W-1:0] data_bank;
   // Both ports on one bank
   logic                  conflict;

   // Code port region decode
   always_comb begin
      code_ok   = 1'b0;
      code_bank = BANK_CODE;
      case (code_addr[DATA_W-1:REGION_LSB])
         REGION_CODE: begin
            code_ok   = code_req;
            code_bank = BANK_CODE;
         end
         REGION_DATA: begin
            code_ok   = code_req;
            code_bank = BANK_DATA;
         end
         // Unmapped region never gets a bank
         default: begin
            code_ok = 1'b0;
         end
      endcase
   end

   // Data port region decode
   always_comb begin
      data_ok   = 1'b0;
      data_bank = BANK_DATA;
      case (data_addr[DATA_W-1:REGION_LSB])
         REGION_CODE: begin
            data_ok   = data_req;
            data_bank = BANK_CODE;
         end
         REGION_DATA: begin
            data_ok   = data_req;
            data_bank = BANK_DATA;
         end
         default: begin
            data_ok = 1'b0;
         end
      endcase
   end

   // Same bank wanted by both, data port wins
   assign conflict = code_ok & data_ok & (code_bank == data_bank);

   // Steer the winner onto each bank
   always_comb begin
      for (int b = 0; b < NUM_BANKS; b++) begin
         bank_en[b]      = 1'b0;
         bank_addr[b]    = '0;
         bank_din[b]     = '0;
         bank_bytesel[b] = '0;
         if (data_ok && (data_bank == BANK_SEL_W'(b))) begin
            bank_en[b]      = 1'b1;
            bank_addr[b]    = data_addr[ADDR_W-1:0];
            bank_din[b]     = data_wdata;
            bank_bytesel[b] = data_bytesel;
         end else if (code_ok && (code_bank == BANK_SEL_W'(b))) begin
            // Fetch only, no lanes written
            bank_en[b]   = 1'b1;
            bank_addr[b] = code_addr[ADDR_W-1:0];
         end
      end
   end

   // Early ready from the granted bank
   assign data_early_ready = data_ok & bank_ready_nxt[data_bank];
   // Code port stalls while losing the bank
   assign code_early_ready = code_ok & ~conflict & bank_ready_nxt[code_bank];

   // Bank each port is steered to this cycle
   assign code_bank_sel = code_bank;
   assign data_bank_sel = data_bank;

endmodule

//--- logic/tcm_response_router.sv
//================================================
// TCM response router, registers grants and
// returns bank read data to each core port
//================================================
`timescale 1ns/1ps

module tcm_response_router (
   input  logic                                               clk,
   input  logic                                               rst_n,
   // Registered read words from the banks
   input  logic [tcm_pkg::NUM_BANKS-1:0][tcm_pkg::DATA_W-1:0] bank_dout,
   // Grants from the request router
   input  logic                                               code_early_ready,
   input  logic                                               data_early_ready,
   input  logic [tcm_pkg::BANK_SEL_W-1:0]                     code_bank_sel,
   input  logic [tcm_pkg::BANK_SEL_W-1:0]                     data_bank_sel,
   // Core side responses
   output logic                                               code_ready_r,
   output logic                                               data_ready_r,
   output logic [tcm_pkg::DATA_W-1:0]                         code_rdata,
   output logic [tcm_pkg::DATA_W-1:0]                         data_rdata
);

   import tcm_pkg::*;

   // Bank that served each port last cycle
   logic [BANK_SEL_W-1:0] code_sel_r;
   logic [BANK_SEL_W-1:0] data_sel_r;

   // Grants follow the bank read by one cycle
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         code_ready_r <= 1'b0;
         data_ready_r <= 1'b0;
         // Each port on its own bank
         code_sel_r   <= BANK_CODE;
         data_sel_r   <= BANK_DATA;
      end else begin
         code_ready_r <= code_early_ready;
         data_ready_r <= data_early_ready;
         code_sel_r   <= code_bank_sel;
         data_sel_r   <= data_bank_sel;
      end
   end

   // Muxed after the edge, covers the crossed case
   assign code_rdata = bank_dout[code_sel_r];
   assign data_rdata = bank_dout[data_sel_r];

endmodule

//--- logic/tcm_subsystem.sv
//================================================
// Dual TCM subsystem, code and data banks shared
// by the core's code and data ports
//================================================
`timescale 1ns/1ps

module tcm_subsystem (
   input  logic                            clk,
   input  logic                            rst_n,
   // Code port
   input  logic [tcm_pkg::DATA_W-1:0]      code_addr,
   input  logic                            code_req,
   output logic                            code_early_ready,
   output logic                            code_ready_r,
   output logic [tcm_pkg::DATA_W-1:0]      code_rdata,
   // Data port
   input  logic [tcm_pkg::DATA_W-1:0]      data_addr,
   input  logic [tcm_pkg::DATA_W-1:0]      data_wdata,
   input  logic [tcm_pkg::BYTESEL_W-1:0]   data_bytesel,
   input  logic                            data_req,
   output logic                            data_early_ready,
   output logic                            data_ready_r,
   output logic [tcm_pkg::DATA_W-1:0]      data_rdata
);

   import tcm_pkg::*;

   // Router to bank buses
   logic [NUM_BANKS-1:0]                 bank_en;
   logic [NUM_BANKS-1:0][ADDR_W-1:0]     bank_addr;
   logic [NUM_BANKS-1:0][DATA_W-1:0]     bank_din;
   logic [NUM_BANKS-1:0][BYTESEL_W-1:0]  bank_bytesel;
   // Bank returns
   logic [NUM_BANKS-1:0][DATA_W-1:0]     bank_dout;
   logic [NUM_BANKS-1:0]                 bank_ready_nxt;
   // Current grants
   logic [BANK_SEL_W-1:0]                code_bank_sel;
   logic [BANK_SEL_W-1:0]                data_bank_sel;

   tcm_request_router u_req_router (
      .code_addr        (code_addr),
      .code_req         (code_req),
      .data_addr        (data_addr),
      .data_wdata       (data_wdata),
      .data_bytesel     (data_bytesel),
      .data_req         (data_req),
      .bank_ready_nxt   (bank_ready_nxt),
      .bank_en          (bank_en),
      .bank_addr        (bank_addr),
      .bank_din         (bank_din),
      .bank_bytesel     (bank_bytesel),
      .code_early_ready (code_early_ready),
      .data_early_ready (data_early_ready),
      .code_bank_sel    (code_bank_sel),
      .data_bank_sel    (data_bank_sel)
   );

   // Bank 0 code space, bank 1 data space
   for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
      tcm_bank u_bank (
         .clk            (clk),
         .rst_n          (rst_n),
         .bank_en        (bank_en[b]),
         .bank_addr      (bank_addr[b]),
         .bank_din       (bank_din[b]),
         .bank_bytesel   (bank_bytesel[b]),
         .bank_dout      (bank_dout[b]),
         .bank_ready_nxt (bank_ready_nxt[b])
      );
   end

   tcm_response_router u_rsp_router (
      .clk              (clk),
      .rst_n            (rst_n),
      .bank_dout        (bank_dout),
      .code_early_ready (code_early_ready),
      .data_early_ready (data_early_ready),
      .code_bank_sel    (code_bank_sel),
      .data_bank_sel    (data_bank_sel),
      .code_ready_r     (code_ready_r),
      .data_ready_r     (data_ready_r),
      .code_rdata       (code_rdata),
      .data_rdata       (data_rdata)
   );

endmodule

//--- test/tcm_subsystem_tb.sv
//================================================
// Testbench for the dual TCM subsystem that checks
// routing, stalls and read data with assertions
//================================================
`timescale 1ns/1ps

module tcm_subsystem_tb;

   // Fixed seed and run bounds
   localparam int unsigned SEED    = 32'h254a;
   localparam int TEST_CYCLES      = 200;
   localparam int TIMEOUT_CYCLES   = 2 * TEST_CYCLES;
   // Region base addresses
   localparam logic [31:0] CODE_BASE = 32'h0000_0000;
   localparam logic [31:0] DATA_BASE = 32'h2000_0000;

   logic        clk;
   logic        rst_n;
   logic [31:0] code_addr;
   logic        code_req;
   logic        code_early_ready;
   logic        code_ready_r;
   logic [31:0] code_rdata;
   logic [31:0] data_addr;
   logic [31:0] data_wdata;
   logic [3:0]  data_bytesel;
   logic        data_req;
   logic        data_early_ready;
   logic        data_ready_r;
   logic [31:0] data_rdata;

   // Reference memory keyed by bank bit and word index
   logic [31:0] model [logic [10:0]];
   // Expected word for the response after an accepted cycle
   logic [31:0] code_exp;
   logic [31:0] data_exp;
   logic        code_exp_known;
   logic        data_exp_known;

   int errors;
   int errors_at_start;
   int checks;
   int tests_run;
   int cycles;

   tcm_subsystem DUT (
      .clk              (clk),
      .rst_n            (rst_n),
      .code_addr        (code_addr),
      .code_req         (code_req),
      .code_early_ready (code_early_ready),
      .code_ready_r     (code_ready_r),
      .code_rdata       (code_rdata),
      .data_addr        (data_addr),
      .data_wdata       (data_wdata),
      .data_bytesel     (data_bytesel),
      .data_req         (data_req),
      .data_early_ready (data_early_ready),
      .data_ready_r     (data_ready_r),
      .data_rdata       (data_rdata)
   );

   // 4 ns period
   always #2 clk = ~clk;

   // Region 4'h2 maps to bank 1 and region 0 to bank 0
   function automatic logic [10:0] model_key(input logic [31:0] a);
      logic bank;
      bank = (a[31:28] == 4'h2);
      return {bank, a[11:2]};
   endfunction

   // Replace only the selected byte lanes
   function automatic logic [31:0] merge_lanes(input logic [31:0] old_w,
                                               input logic [31:0] new_w,
                                               input logic [3:0]  sel);
      logic [31:0] w;
      w = old_w;
      for (int i = 0; i < 4; i++) begin
         if (sel[i]) begin
            w[i*8 +: 8] = new_w[i*8 +: 8];
         end
      end
      return w;
   endfunction

   // Model update and expected words on each accepted cycle
   always @(posedge clk) begin : model_track
      logic [10:0] ck;
      logic [10:0] dk;
      ck = model_key(code_addr);
      dk = model_key(data_addr);
      if (rst_n) begin
         if (code_ready_r) checks++;
         if (data_ready_r) checks++;
         if (code_early_ready) begin
            code_exp_known <= model.exists(ck);
            code_exp       <= model.exists(ck) ? model[ck] : 32'h0;
         end
         // Old contents come back even on a write
         if (data_early_ready) begin
            data_exp_known <= model.exists(dk);
            data_exp       <= model.exists(dk) ? model[dk] : 32'h0;
            if (data_bytesel != 4'h0) begin
               model[dk] = merge_lanes(model.exists(dk) ? model[dk] : 32'hx,
                                       data_wdata, data_bytesel);
            end
         end
      end
   end

   // Read data one cycle after acceptance
   code_rdata_check: assert property (@(posedge clk) disable iff (!rst_n)
      code_early_ready |=> code_ready_r && (!code_exp_known || code_rdata == code_exp))
      else begin
         errors++;
         $display("[FAIL] %0t: code rdata %h, expected %h", $time,
                  $sampled(code_rdata), $sampled(code_exp));
      end

   data_rdata_check: assert property (@(posedge clk) disable iff (!rst_n)
      data_early_ready |=> data_ready_r && (!data_exp_known || data_rdata == data_exp))
      else begin
         errors++;
         $display("[FAIL] %0t: data rdata %h, expected %h", $time,
                  $sampled(data_rdata), $sampled(data_exp));
      end

   // No ready without an accepted cycle before it
   code_idle_check: assert property (@(posedge clk) disable iff (!rst_n)
      !code_early_ready |=> !code_ready_r)
      else begin
         errors++;
         $display("[FAIL] %0t: code_ready_r high without a request", $time);
      end

   data_idle_check: assert property (@(posedge clk) disable iff (!rst_n)
      !data_early_ready |=> !data_ready_r)
      else begin
         errors++;
         $display("[FAIL] %0t: data_ready_r high without a request", $time);
      end

   // Stall only on a shared bank with the data port first
   always @(posedge clk) begin
      if (rst_n) begin
         if (code_req && data_req && model_key(code_addr) >> 10 == model_key(data_addr) >> 10)
         begin
            stall_check: assert (!code_early_ready && data_early_ready)
               else begin
                  errors++;
                  $display("[FAIL] %0t: shared bank, code %b data %b", $time,
                           code_early_ready, data_early_ready);
               end
         end else begin
            grant_check: assert (code_early_ready == code_req && data_early_ready == data_req)
               else begin
                  errors++;
                  $display("[FAIL] %0t: early ready code %b data %b", $time,
                           code_early_ready, data_early_ready);
               end
         end
      end
   end

   // Hard stop
   always @(posedge clk) begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout: run still going after %0d cycles", cycles);
         $display("Done: errors found");
         $finish;
      end
   end

   task automatic drive_code(input logic [31:0] a);
      code_req  = 1'b1;
      code_addr = a;
   endtask

   // Zero byte selects make a read
   task automatic drive_data(input logic [31:0] a, input logic [31:0] wd,
                             input logic [3:0] sel);
      data_req     = 1'b1;
      data_addr    = a;
      data_wdata   = wd;
      data_bytesel = sel;
   endtask

   // Drop each request accepted on this clock
   task automatic step_cycle();
      bit code_acc;
      bit data_acc;
      @(posedge clk);
      code_acc = code_req && code_early_ready;
      data_acc = data_req && data_early_ready;
      #1;
      if (code_acc) code_req = 1'b0;
      if (data_acc) begin
         data_req     = 1'b0;
         data_bytesel = 4'h0;
      end
   endtask

   task automatic wait_accept();
      while (code_req || data_req) step_cycle();
   endtask

   // Extra cycle lets the last response be checked
   task automatic finish_test(input string name);
      @(posedge clk);
      #1;
      tests_run++;
      if (errors == errors_at_start) $display("Test %0d %s: ok", tests_run, name);
      else $display("Test %0d %s: %0d errors", tests_run, name, errors - errors_at_start);
      errors_at_start = errors;
   endtask

   initial begin
      clk          = 1'b0;
      rst_n        = 1'b0;
      code_addr    = 32'h0;
      code_req     = 1'b0;
      data_addr    = 32'h0;
      data_wdata   = 32'h0;
      data_bytesel = 4'h0;
      data_req     = 1'b0;
      void'($urandom(SEED));
      repeat (4) @(posedge clk);
      #1 rst_n = 1'b1;

      // Quiet after reset
      reset_check: assert (!code_ready_r && !data_ready_r)
         else begin
            errors++;
            $display("[FAIL] %0t: ready flags set after reset", $time);
         end
      repeat (5) @(posedge clk);
      #1;
      finish_test("reset");

      // Full fill first and then partial lanes read back
      for (int i = 0; i < 8; i++) begin
         drive_data(DATA_BASE + 32'(4 * i), $urandom(), 4'hf);
         wait_accept();
      end
      for (int i = 0; i < 8; i++) begin
         drive_data(DATA_BASE + 32'(4 * i), $urandom(), 4'((i * 5 + 3) % 16));
         wait_accept();
         drive_data(DATA_BASE + 32'(4 * i), 32'h0, 4'h0);
         wait_accept();
      end
      finish_test("byte_select");

      // Code bank preload goes through the data port
      for (int i = 0; i < 8; i++) begin
         drive_data(CODE_BASE + 32'(4 * i), $urandom(), 4'hf);
         wait_accept();
      end
      for (int i = 0; i < 4; i++) begin
         drive_code(CODE_BASE + 32'(4 * i));
         drive_data(DATA_BASE + 32'(4 * i), 32'h0, 4'h0);
         wait_accept();
      end
      finish_test("parallel");

      // Data into code space and fetch from data space
      for (int i = 0; i < 4; i++) begin
         drive_code(DATA_BASE + 32'(4 * (i + 4)));
         drive_data(CODE_BASE + 32'(4 * i), $urandom(), (i % 2 == 0) ? 4'b0110 : 4'b0000);
         wait_accept();
      end
      finish_test("crossed");

      // Data port holds bank 1 for three cycles
      drive_code(DATA_BASE + 32'h1c);
      for (int i = 0; i < 3; i++) begin
         drive_data(DATA_BASE + 32'(4 * i), $urandom(), (i == 1) ? 4'h3 : 4'h0);
         while (data_req) step_cycle();
      end
      wait_accept();
      // Same fight on bank 0
      drive_code(CODE_BASE + 32'h4);
      drive_data(CODE_BASE + 32'h8, 32'h0, 4'h0);
      wait_accept();
      finish_test("conflict");

      // New request on both ports every cycle
      for (int i = 0; i < 8; i++) begin
         drive_code(CODE_BASE + 32'(4 * i));
         drive_data(DATA_BASE + 32'(4 * (7 - i)), 32'h0, 4'h0);
         wait_accept();
      end
      finish_test("pipelined");

      $display("Tests run: %0d, response checks: %0d, errors: %0d", tests_run, checks, errors);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule
